/* Bender.yml */
package:
  name: arcade_video

sources:
  - logic/videoPkg.sv
  - logic/videoBus.sv
  - logic/videoTiming.sv
  - logic/regFile.sv
  - logic/patternGen.sv
  - logic/paletteLookup.sv
  - logic/videoOut.sv
  - logic/videoTop.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/videoTb.sv

/* list.f */
+incdir+tb
logic/videoPkg.sv
logic/videoBus.sv
logic/videoTiming.sv
logic/regFile.sv
logic/patternGen.sv
logic/paletteLookup.sv
logic/videoOut.sv
logic/videoTop.sv
tb/videoTb.sv

/* logic/paletteLookup.sv */
`timescale 1ns/1ps
// palette stage
// maps the colour index to 12-bit RGB through the 16-entry palette
module paletteLookup (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic                      pixCen,
    input  logic [videoPkg::rgbW-1:0] palette [videoPkg::palSize],
    videoBus.snk                      prev,
    videoBus.src                      next
);
    import videoPkg::*;

    // timing fields move along unchanged
    always_ff @(posedge clk) begin
        if (!rstN) begin
            next.hdump <= '0;
            next.vdump <= '0;
            next.hb    <= 1'b1;  // blank until the pipeline fills
            next.vb    <= 1'b1;
            next.hs    <= 1'b0;
            next.vs    <= 1'b0;
        end else if (pixCen) begin
            next.hdump <= prev.hdump;
            next.vdump <= prev.vdump;
            next.hb    <= prev.hb;
            next.vb    <= prev.vb;
            next.hs    <= prev.hs;
            next.vs    <= prev.vs;
        end
    end

    // colour payload
    always_ff @(posedge clk) begin
        if (pixCen) begin
            next.rgb      <= palette[prev.colIndex];  // live palette, new words show at once
            next.colIndex <= prev.colIndex;
        end
    end

endmodule

/* logic/patternGen.sv */
`timescale 1ns/1ps
// test pattern stage
// turns the scrolled raster position into a 4-bit colour index
module patternGen (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic                      pixCen,
    input  videoPkg::patMode          mode,
    input  logic [videoPkg::cntW-1:0] scrollX,
    input  logic [videoPkg::cntW-1:0] scrollY,
    input  logic [videoPkg::idxW-1:0] solidIdx,
    videoBus.snk                      prev,
    videoBus.src                      next
);
    import videoPkg::*;

    logic [cntW-1:0] x;
    logic [cntW-1:0] y;
    logic [idxW-1:0] idx;

    assign x = prev.hdump + scrollX;  // wraps modulo 512
    assign y = prev.vdump + scrollY;

    always_comb begin
        case (mode)
            patChecker: idx = x[6:3] ^ y[6:3];     // 8x8 cells
            patBars:    idx = x[cntW-1 -: idxW];   // 32 pixel wide bars
            default:    idx = solidIdx;
        endcase
    end

    assign next.rgb = '0;  // filled in by the palette stage

    // timing fields
    always_ff @(posedge clk) begin
        if (!rstN) begin
            next.hdump <= '0;
            next.vdump <= '0;
            next.hb    <= 1'b1;
            next.vb    <= 1'b1;
            next.hs    <= 1'b0;
            next.vs    <= 1'b0;
        end else if (pixCen) begin
            next.hdump <= prev.hdump;
            next.vdump <= prev.vdump;
            next.hb    <= prev.hb;
            next.vb    <= prev.vb;
            next.hs    <= prev.hs;
            next.vs    <= prev.vs;
        end
    end

    always_ff @(posedge clk) begin
        if (pixCen) next.colIndex <= idx;
    end

endmodule

/* logic/regFile.sv */
`timescale 1ns/1ps
// AXI4-Lite configuration slave
// holds pattern mode, scroll offsets, solid index and the 16 palette words
module regFile #(
    parameter int addrBits = 7
) (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic [addrBits-1:0]           awaddr,
    input  logic                          awvalid,
    output logic                          awready,
    input  logic [31:0]                   wdata,
    input  logic [3:0]                    wstrb,
    input  logic                          wvalid,
    output logic                          wready,
    output videoPkg::axiResp              bresp,
    output logic                          bvalid,
    input  logic                          bready,
    input  logic [addrBits-1:0]           araddr,
    input  logic                          arvalid,
    output logic                          arready,
    output logic [31:0]                   rdata,
    output videoPkg::axiResp              rresp,
    output logic                          rvalid,
    input  logic                          rready,
    output videoPkg::patMode              mode,
    output logic [videoPkg::cntW-1:0]     scrollX,
    output logic [videoPkg::cntW-1:0]     scrollY,
    output logic [videoPkg::idxW-1:0]     solidIdx,
    output logic [videoPkg::rgbW-1:0]     palette [videoPkg::palSize]
);
    import videoPkg::*;

    typedef enum logic {wIdle, wResp} wrState;
    typedef enum logic {rIdle, rResp} rdState;

    wrState              wState;
    rdState              rState;
    logic                awHeld;   // address arrived before data
    logic                wHeld;    // data arrived before address
    logic [addrBits-1:0] awAddrQ;
    logic [31:0]         wDataQ;
    logic [3:0]          wStrbQ;
    logic [addrBits-1:0] wrAddr;
    logic [31:0]         wrData;
    logic [3:0]          wrStrb;
    logic [31:0]         curWord;
    logic [31:0]         wrWord;
    logic                doWrite;
    logic                wrOk;

    function automatic int unsigned wordAddr(input logic [addrBits-1:0] a);
        return int'({a[addrBits-1:2], 2'b00});
    endfunction

    function automatic logic isMapped(input logic [addrBits-1:0] a);
        int unsigned w;
        w = wordAddr(a);
        return w == regCtrl || w == regScroll || w == regSolid ||
               (w >= palBase && w < palBase + 4 * palSize);
    endfunction

    // stored fields of a register, zero when unmapped
    function automatic logic [31:0] regValue(input logic [addrBits-1:0] a);
        int unsigned w;
        logic [31:0] v;
        w = wordAddr(a);
        v = '0;
        if (w == regCtrl) v[1:0] = mode;
        else if (w == regScroll) v = {7'd0, scrollY, 7'd0, scrollX};
        else if (w == regSolid) v[idxW-1:0] = solidIdx;
        else if (isMapped(a)) v[rgbW-1:0] = palette[a[2 +: idxW]];
        return v;
    endfunction

    // held halves take priority over the live channel
    assign wrAddr  = awHeld ? awAddrQ : awaddr;
    assign wrData  = wHeld ? wDataQ : wdata;
    assign wrStrb  = wHeld ? wStrbQ : wstrb;
    assign doWrite = wState == wIdle && (awHeld || awvalid) && (wHeld || wvalid);
    assign wrOk    = isMapped(wrAddr);
    assign curWord = regValue(wrAddr);

    assign awready = wState == wIdle && !awHeld;
    assign wready  = wState == wIdle && !wHeld;
    assign bvalid  = wState == wResp;
    assign arready = rState == rIdle;
    assign rvalid  = rState == rResp;

    // per byte merge with the stored value
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            wrWord[8*i +: 8] = wrStrb[i] ? wrData[8*i +: 8] : curWord[8*i +: 8];
        end
    end

    // write channel FSM
    always_ff @(posedge clk) begin
        if (!rstN) begin
            wState <= wIdle;
            awHeld <= 1'b0;
            wHeld  <= 1'b0;
            bresp  <= respOkay;
        end else if (doWrite) begin
            wState <= wResp;
            awHeld <= 1'b0;
            wHeld  <= 1'b0;
            bresp  <= wrOk ? respOkay : respSlvErr;
        end else if (wState == wIdle) begin
            if (awvalid && awready) awHeld <= 1'b1;
            if (wvalid && wready) wHeld <= 1'b1;
        end else if (bready) begin
            wState <= wIdle;  // response taken
        end
    end

    always_ff @(posedge clk) begin
        if (awvalid && awready) awAddrQ <= awaddr;
        if (wvalid && wready) begin
            wDataQ <= wdata;
            wStrbQ <= wstrb;
        end
    end

    // configuration registers
    always_ff @(posedge clk) begin
        if (!rstN) begin
            mode     <= patSolid;
            scrollX  <= '0;
            scrollY  <= '0;
            solidIdx <= '0;
            for (int i = 0; i < palSize; i++) palette[i] <= '0;
        end else if (doWrite && wrOk) begin
            if (wordAddr(wrAddr) == regCtrl) begin
                mode <= (wrWord[1:0] == 2'd3) ? patSolid : patMode'(wrWord[1:0]);
            end else if (wordAddr(wrAddr) == regScroll) begin
                scrollX <= wrWord[8:0];
                scrollY <= wrWord[24:16];
            end else if (wordAddr(wrAddr) == regSolid) begin
                solidIdx <= wrWord[idxW-1:0];
            end else begin
                palette[wrAddr[2 +: idxW]] <= wrWord[rgbW-1:0];
            end
        end
    end

    // read channel FSM
    always_ff @(posedge clk) begin
        if (!rstN) begin
            rState <= rIdle;
            rresp  <= respOkay;
        end else if (rState == rIdle) begin
            if (arvalid) begin
                rState <= rResp;
                rresp  <= isMapped(araddr) ? respOkay : respSlvErr;
            end
        end else if (rready) begin
            rState <= rIdle;
        end
    end

    always_ff @(posedge clk) begin
        if (arvalid && arready) rdata <= regValue(araddr);  // zero when unmapped
    end

endmodule

/* logic/videoBus.sv */
`timescale 1ns/1ps
// stage to stage video bundle
// raster position with blanks and syncs, plus the colour as it gets built
interface videoBus;
    import videoPkg::*;

    logic [cntW-1:0] hdump;     // column of this pixel
    logic [cntW-1:0] vdump;     // line of this pixel
    logic            hb;
    logic            vb;
    logic            hs;
    logic            vs;
    logic [idxW-1:0] colIndex;  // valid after patternGen
    logic [rgbW-1:0] rgb;       // valid after paletteLookup

    // driving stage
    modport src (
        output hdump, vdump, hb, vb, hs, vs, colIndex, rgb
    );

    // receiving stage
    modport snk (
        input hdump, vdump, hb, vb, hs, vs, colIndex, rgb
    );

endinterface

/* logic/videoOut.sv */
`timescale 1ns/1ps
// video output stage
// blanks the colour and registers colour, syncs and counters together
module videoOut (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic                      pixCen,
    videoBus.snk                      prev,
    output logic [3:0]                red,
    output logic [3:0]                green,
    output logic [3:0]                blue,
    output logic                      hsync,
    output logic                      vsync,
    output logic                      hblank,
    output logic                      vblank,
    output logic [videoPkg::cntW-1:0] hdump,
    output logic [videoPkg::cntW-1:0] vdump
);
    import videoPkg::*;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            {red, green, blue} <= '0;
            hsync  <= 1'b0;
            vsync  <= 1'b0;
            hblank <= 1'b1;
            vblank <= 1'b1;
            hdump  <= '0;
            vdump  <= '0;
        end else if (pixCen) begin
            {red, green, blue} <= (prev.hb || prev.vb) ? rgbW'(0) : prev.rgb;  // black in blanking
            hsync  <= prev.hs;
            vsync  <= prev.vs;
            hblank <= prev.hb;
            vblank <= prev.vb;
            hdump  <= prev.hdump;  // position of the pixel now shown
            vdump  <= prev.vdump;
        end
    end

endmodule

/* logic/videoPkg.sv */
// video subsystem shared definitions
// raster geometry, datapath widths, pattern and response enums, register map
package videoPkg;

    // raster geometry in pixel ticks and lines
    localparam int hTotal    = 512;
    localparam int vTotal    = 262;
    localparam int hVisStart = 64;   // first visible column
    localparam int hVisEnd   = 448;  // first blanked column after the picture
    localparam int vVisStart = 14;
    localparam int vVisEnd   = 237;  // last visible line
    localparam int hsLen     = 18;   // hsync width in ticks
    localparam int vsLen     = 4;    // vsync length in lines

    // datapath widths
    localparam int cntW    = 9;
    localparam int idxW    = 4;
    localparam int rgbW    = 12;  // four bits per channel
    localparam int palSize = 16;

    // test pattern selection
    typedef enum logic [1:0] {
        patSolid   = 2'd0,
        patChecker = 2'd1,
        patBars    = 2'd2
    } patMode;

    // AXI response codes in use
    typedef enum logic [1:0] {
        respOkay   = 2'b00,
        respSlvErr = 2'b10
    } axiResp;

    // byte addresses of the register map
    localparam int unsigned regCtrl   = 'h00;
    localparam int unsigned regScroll = 'h04;
    localparam int unsigned regSolid  = 'h08;
    localparam int unsigned palBase   = 'h40;  // 16 words up to 0x7c

endpackage

/* logic/videoTiming.sv */
`timescale 1ns/1ps
// raster timing generator
// 512 ticks per line and 262 lines per frame, advanced by the pixel enable
// produces counters, blanking and syncs, all registered together
module videoTiming #(
    parameter int hsStart = 487,
    parameter int vsStart = 251
) (
    input  logic clk,
    input  logic rstN,
    input  logic pixCen,
    videoBus.src bus
);
    import videoPkg::*;

    localparam logic [cntW-1:0] hsRise = cntW'(hsStart);
    localparam logic [cntW-1:0] hsFall = cntW'((hsStart + hsLen) % hTotal);  // may wrap
    localparam logic [cntW-1:0] vsRise = cntW'(vsStart);
    localparam logic [cntW-1:0] vsFall = cntW'((vsStart + vsLen) % vTotal);

    logic [cntW-1:0] hCnt;
    logic [cntW-1:0] vCnt;
    logic [cntW-1:0] vNext;
    logic            lineEnd;
    logic            vbPre;   // blank flag of the coming line
    logic            vbLine;  // blank flag of the current line

    assign lineEnd = hCnt == cntW'(hTotal - 1);
    assign vNext   = (vCnt == cntW'(vTotal - 1)) ? '0 : vCnt + 1'b1;

    // no colour exists yet at this point of the pipeline
    assign bus.colIndex = '0;
    assign bus.rgb      = '0;

    // raw counters
    always_ff @(posedge clk) begin
        if (!rstN) begin
            hCnt   <= '0;
            vCnt   <= '0;
            vbPre  <= 1'b1;
            vbLine <= 1'b1;  // line 0 is blanked
        end else if (pixCen) begin
            hCnt  <= lineEnd ? '0 : hCnt + 1'b1;
            vbPre <= vNext < vVisStart || vNext > vVisEnd;  // one line early
            if (lineEnd) begin
                vCnt   <= vNext;
                vbLine <= vbPre;  // shifted in at the line wrap only
            end
        end
    end

    // bus fields, one tick behind the counter value they describe
    always_ff @(posedge clk) begin
        if (!rstN) begin
            bus.hdump <= '0;
            bus.vdump <= '0;
            bus.hb    <= 1'b1;
            bus.vb    <= 1'b1;
            bus.hs    <= 1'b0;
            bus.vs    <= 1'b0;
        end else if (pixCen) begin
            bus.hdump <= hCnt;
            bus.vdump <= vCnt;
            bus.hb    <= hCnt >= hVisEnd || hCnt < hVisStart;
            bus.vb    <= vbLine;
            if (hCnt == hsRise) begin
                bus.hs <= 1'b1;
                // vsync edges locked to the hsync rising tick
                if (vCnt == vsRise) bus.vs <= 1'b1;
                if (vCnt == vsFall) bus.vs <= 1'b0;
            end
            if (hCnt == hsFall) bus.hs <= 1'b0;
        end
    end

endmodule

/* logic/videoTop.sv */
`timescale 1ns/1ps
// arcade video subsystem top
// AXI4-Lite config slave feeding a timing, pattern, palette and output pipeline
module videoTop #(
    parameter int hsStart  = 487,
    parameter int vsStart  = 251,
    parameter int addrBits = 7
) (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic [addrBits-1:0]       awaddr,
    input  logic                      awvalid,
    output logic                      awready,
    input  logic [31:0]               wdata,
    input  logic [3:0]                wstrb,
    input  logic                      wvalid,
    output logic                      wready,
    output videoPkg::axiResp          bresp,
    output logic                      bvalid,
    input  logic                      bready,
    input  logic [addrBits-1:0]       araddr,
    input  logic                      arvalid,
    output logic                      arready,
    output logic [31:0]               rdata,
    output videoPkg::axiResp          rresp,
    output logic                      rvalid,
    input  logic                      rready,
    input  logic                      pixCen,
    output logic [3:0]                red,
    output logic [3:0]                green,
    output logic [3:0]                blue,
    output logic                      hsync,
    output logic                      vsync,
    output logic                      hblank,
    output logic                      vblank,
    output logic [videoPkg::cntW-1:0] hdump,
    output logic [videoPkg::cntW-1:0] vdump
);
    import videoPkg::*;

    // configuration from the register file
    patMode          mode;
    logic [cntW-1:0] scrollX;
    logic [cntW-1:0] scrollY;
    logic [idxW-1:0] solidIdx;
    logic [rgbW-1:0] palette [palSize];

    // pipeline links
    videoBus timBus ();
    videoBus patBus ();
    videoBus palBus ();

    regFile #(.addrBits(addrBits)) uRegs (.*);

    videoTiming #(
        .hsStart(hsStart),
        .vsStart(vsStart)
    ) uTiming (
        .clk(clk),
        .rstN(rstN),
        .pixCen(pixCen),
        .bus(timBus)
    );

    patternGen uPattern (.prev(timBus), .next(patBus), .*);

    paletteLookup uPalette (.prev(patBus), .next(palBus), .*);

    videoOut uOut (.prev(palBus), .*);

endmodule

/* tb/videoTbTasks.svh */
// AXI4-Lite master tasks and typed compare tasks for the video testbench
// included inside the testbench module, so they drive its signals directly
`ifndef VIDEO_TB_TASKS_SVH
`define VIDEO_TB_TASKS_SVH

// one write, both channels offered together, response taken when it shows
task automatic axiWrite(input logic [addrBits-1:0] addr, input logic [31:0] data,
                        input logic [3:0] strb, output axiResp resp);
    @(posedge clk);
    #2;
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = 1'b1;
    @(negedge clk);
    while (!(awready && wready)) @(negedge clk);
    @(posedge clk);  // address and data transfer here
    #2;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    @(negedge clk);
    while (!bvalid) @(negedge clk);
    resp = bresp;
    applyWrite(addr, data, strb);  // shadow follows once bvalid is seen
    @(posedge clk);
    #2;
    bready = 1'b0;
endtask

task automatic axiRead(input logic [addrBits-1:0] addr, output logic [31:0] data,
                       output axiResp resp);
    @(posedge clk);
    #2;
    araddr  = addr;
    arvalid = 1'b1;
    rready  = 1'b1;
    @(negedge clk);
    while (!arready) @(negedge clk);
    @(posedge clk);  // address transfer
    #2;
    arvalid = 1'b0;
    @(negedge clk);
    while (!rvalid) @(negedge clk);
    data = rdata;
    resp = rresp;
    @(posedge clk);
    #2;
    rready = 1'b0;
endtask

task automatic compareRgb(input logic [rgbW-1:0] got, input logic [rgbW-1:0] exp,
                          input string what, inout int tally);
    if (got !== exp) begin
        errors++;
        tally++;
        if (errors <= maxShown)
            $display("[FAIL] %0d ns: %s at (%0d,%0d) got %03h expected %03h",
                     $time, what, hdump, vdump, got, exp);
    end
endtask

task automatic compareResp(input axiResp got, input axiResp exp, input string what,
                           inout int tally);
    if (got !== exp) begin
        errors++;
        tally++;
        if (errors <= maxShown)
            $display("[FAIL] %0d ns: %s got %s expected %s", $time, what, got.name(), exp.name());
    end
endtask

task automatic compareData(input logic [31:0] got, input logic [31:0] exp, input string what,
                           inout int tally);
    if (got !== exp) begin
        errors++;
        tally++;
        if (errors <= maxShown)
            $display("[FAIL] %0d ns: %s got %08h expected %08h", $time, what, got, exp);
    end
endtask

// raster measurements in ticks, lines or edges
task automatic compareCount(input int got, input int exp, input string what, inout int tally);
    if (got != exp) begin
        errors++;
        tally++;
        if (errors <= maxShown)
            $display("[FAIL] %0d ns: %s got %0d expected %0d", $time, what, got, exp);
    end
endtask

`endif

/* tb/videoTb.sv */
`timescale 1ns/1ps
// testbench for the arcade video subsystem
// drives the AXI4-Lite slave, watches the raster outputs on every pixel tick
// and compares the colour with a model fed from a shadow of the registers
module videoTb;
    import videoPkg::*;

    localparam int     addrBits  = 7;
    localparam int     clkPeriod = 20;
    localparam int     visPixels = (hVisEnd - hVisStart) * (vVisEnd - vVisStart + 1);
    localparam longint frameNs   = longint'(hTotal) * vTotal * 2 * clkPeriod;  // tick = 2 clocks
    localparam longint timeoutNs = 7 * frameNs;  // five test frames plus slack
    localparam int     maxShown  = 40;           // failure lines printed before going quiet

    logic                clk     = 1'b0;
    logic                rstN    = 1'b0;
    logic                pixCen  = 1'b0;
    logic [addrBits-1:0] awaddr  = '0;
    logic                awvalid = 1'b0;
    logic                awready;
    logic [31:0]         wdata   = '0;
    logic [3:0]          wstrb   = '0;
    logic                wvalid  = 1'b0;
    logic                wready;
    axiResp              bresp;
    logic                bvalid;
    logic                bready  = 1'b0;
    logic [addrBits-1:0] araddr  = '0;
    logic                arvalid = 1'b0;
    logic                arready;
    logic [31:0]         rdata;
    axiResp              rresp;
    logic                rvalid;
    logic                rready  = 1'b0;
    logic [3:0]          red;
    logic [3:0]          green;
    logic [3:0]          blue;
    logic                hsync;
    logic                vsync;
    logic                hblank;
    logic                vblank;
    logic [cntW-1:0]     hdump;
    logic [cntW-1:0]     vdump;

    // register shadow, updated on each write response
    patMode          shMode    = patSolid;
    logic [cntW-1:0] shScrollX = '0;
    logic [cntW-1:0] shScrollY = '0;
    logic [idxW-1:0] shSolid   = '0;
    logic [rgbW-1:0] shPal [palSize] = '{default: '0};

    int     seed        = 41;
    bit     running     = 1'b0;
    bit     checkEn     = 1'b1;   // pixel compare on
    bit     tickAt      = 1'b0;   // last rising edge was a pixel tick
    longint pixTicks    = 0;
    int     errors      = 0;
    int     axiErr      = 0;
    int     pixErr      = 0;
    int     blankErr    = 0;
    int     rasterErr   = 0;
    int     passTests   = 0;
    int     failTests   = 0;
    int     visChecks   = 0;
    int     blankChecks = 0;
    int     mark;
    int     visMark;

    // raster bookkeeping
    bit     prevHs      = 1'b0;
    bit     prevVs      = 1'b0;
    bit     prevHb      = 1'b1;
    bit     prevVb      = 1'b1;
    longint lastHsTick  = -1;
    int     hsCount     = 0;
    int     lastVsHs    = -1;  // hsync count at the last vsync rise
    int     vsHighLines = 0;
    int     hbLowTicks  = 0;
    int     vbLowLines  = 0;
    int     hsMeas      = 0;
    int     vsMeas      = 0;
    int     vsLenMeas   = 0;
    int     hbMeas      = 0;
    int     vbMeas      = 0;

    videoTop #(.addrBits(addrBits)) DUT (.*);

    always #(clkPeriod / 2) clk = ~clk;

    // pixel enable on every second clock
    always @(posedge clk) begin
        #2;
        pixCen = ~pixCen;
    end

    always @(posedge clk) tickAt <= pixCen;

    function automatic bit isMappedAddr(input logic [addrBits-1:0] a);
        int unsigned w;
        w = {a[addrBits-1:2], 2'b00};
        return w == regCtrl || w == regScroll || w == regSolid ||
               (w >= palBase && w < palBase + 4 * palSize);
    endfunction

    function automatic axiResp expectedResp(input logic [addrBits-1:0] a);
        if (isMappedAddr(a)) return respOkay;
        return respSlvErr;
    endfunction

    // register word as the map lays out the stored fields
    function automatic logic [31:0] shadowWord(input logic [addrBits-1:0] a);
        int unsigned w;
        logic [31:0] v;
        w = {a[addrBits-1:2], 2'b00};
        v = '0;
        if (!isMappedAddr(a)) return v;
        if (w == regCtrl) v[1:0] = shMode;
        else if (w == regScroll) v = {7'd0, shScrollY, 7'd0, shScrollX};
        else if (w == regSolid) v[3:0] = shSolid;
        else v[11:0] = shPal[(w - palBase) / 4];
        return v;
    endfunction

    function automatic void applyWrite(input logic [addrBits-1:0] a, input logic [31:0] d,
                                       input logic [3:0] s);
        int unsigned w;
        logic [31:0] m;
        w = {a[addrBits-1:2], 2'b00};
        m = shadowWord(a);
        for (int i = 0; i < 4; i++) begin
            if (s[i]) m[8*i +: 8] = d[8*i +: 8];  // only enabled bytes
        end
        if (!isMappedAddr(a)) return;
        if (w == regCtrl) begin
            shMode = (m[1:0] == 2'd3) ? patSolid : patMode'(m[1:0]);  // 3 falls back to solid
        end else if (w == regScroll) begin
            shScrollX = m[8:0];
            shScrollY = m[24:16];
        end else if (w == regSolid) begin
            shSolid = m[3:0];
        end else begin
            shPal[(w - palBase) / 4] = m[11:0];
        end
    endfunction

    // colour of the pixel at column h, line v
    function automatic logic [rgbW-1:0] expectedRgb(input logic [cntW-1:0] h,
                                                    input logic [cntW-1:0] v);
        logic [cntW-1:0] x;
        logic [cntW-1:0] y;
        logic [idxW-1:0] idx;
        if (h < hVisStart || h >= hVisEnd || v < vVisStart || v > vVisEnd) return '0;
        x = h + shScrollX;  // 9 bit sums wrap modulo 512
        y = v + shScrollY;
        case (shMode)
            patChecker: idx = x[6:3] ^ y[6:3];  // cell column xor cell row
            patBars:    idx = x[8:5];
            default:    idx = shSolid;
        endcase
        return shPal[idx];
    endfunction

    `include "videoTbTasks.svh"

    task automatic waitTicks(input int n);
        longint target;
        target = pixTicks + n;
        wait (pixTicks >= target);
    endtask

    task automatic waitVsRise();
        @(posedge vsync);
    endtask

    task automatic configWrite(input logic [addrBits-1:0] addr, input logic [31:0] data,
                               input logic [3:0] strb);
        axiResp resp;
        checkEn = 1'b0;  // pixels in flight may carry either setting
        axiWrite(addr, data, strb, resp);
        compareResp(resp, expectedResp(addr), $sformatf("write response at %02h", addr), axiErr);
        waitTicks(3);
        checkEn = 1'b1;
    endtask

    task automatic readCheck(input logic [addrBits-1:0] addr);
        logic [31:0] data;
        axiResp      resp;
        axiRead(addr, data, resp);
        compareResp(resp, expectedResp(addr), $sformatf("read response at %02h", addr), axiErr);
        compareData(data, shadowWord(addr), $sformatf("read data at %02h", addr), axiErr);
    endtask

    task automatic reportTest(input string name, input bit ok);
        if (ok) begin
            passTests++;
            $display("test %-20s ok", name);
        end else begin
            failTests++;
            $display("test %-20s failed", name);
        end
    endtask

    // one full visible frame in the given mode with random scroll
    task automatic runPattern(input patMode m, input string name);
        int startErr;
        int startVis;
        startErr = pixErr + axiErr;
        configWrite(regCtrl, {30'd0, m}, 4'hf);
        configWrite(regScroll, $random(seed), 4'hf);
        configWrite(regSolid, $random(seed), 4'hf);
        startVis = visChecks;
        waitVsRise();
        compareCount(visChecks - startVis, visPixels, "visible pixels checked", pixErr);
        reportTest(name, pixErr + axiErr == startErr);
    endtask

    // pixel checker and raster measurements, once per pixel tick
    always @(negedge clk) begin
        if (running && tickAt) begin
            pixTicks++;
            if (hblank || vblank) begin
                compareRgb({red, green, blue}, '0, "blanked colour", blankErr);
                blankChecks++;
            end
            if (checkEn) begin
                compareRgb({red, green, blue}, expectedRgb(hdump, vdump), "pixel colour", pixErr);
                if (!hblank && !vblank) visChecks++;
            end
            if (hsync && !prevHs) begin
                if (lastHsTick >= 0) begin
                    compareCount(int'(pixTicks - lastHsTick), hTotal, "ticks per line", rasterErr);
                    hsMeas++;
                end
                lastHsTick = pixTicks;
                hsCount++;
                if (vsync) vsHighLines++;
            end
            if (vsync && !prevVs) begin
                if (lastVsHs >= 0) begin
                    compareCount(hsCount - lastVsHs, vTotal, "lines per frame", rasterErr);
                    vsMeas++;
                end
                lastVsHs = hsCount;
            end
            if (!vsync && prevVs) begin
                compareCount(vsHighLines, vsLen, "lines in vsync", rasterErr);
                vsLenMeas++;
                vsHighLines = 0;
            end
            if (!hblank) hbLowTicks++;
            if (hblank && !prevHb) begin
                compareCount(hbLowTicks, hVisEnd - hVisStart, "visible ticks per line", rasterErr);
                hbMeas++;
                hbLowTicks = 0;
            end
            if (!vblank && hdump == 0) vbLowLines++;
            if (vblank && !prevVb) begin
                compareCount(vbLowLines, vVisEnd - vVisStart + 1, "visible lines", rasterErr);
                vbMeas++;
                vbLowLines = 0;
            end
            prevHs = hsync;
            prevVs = vsync;
            prevHb = hblank;
            prevVb = vblank;
        end
    end

    // watchdog
    initial begin
        #(timeoutNs);
        $display("timeout: the run did not finish within %0d ns", timeoutNs);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        repeat (16) @(posedge clk);
        #2;
        rstN    = 1'b1;
        running = 1'b1;

        mark = axiErr;
        configWrite(regCtrl, 32'hffff_fff2, 4'hf);  // bars plus junk above the field
        readCheck(regCtrl);
        configWrite(regCtrl, 32'h0000_0003, 4'hf);  // illegal mode
        readCheck(regCtrl);
        configWrite(regScroll, 32'hffff_ffff, 4'hf);
        readCheck(regScroll);
        configWrite(regSolid, 32'h0000_00ab, 4'hf);
        readCheck(regSolid);
        for (int i = 0; i < palSize; i++) begin
            configWrite(addrBits'(palBase + 4 * i), $random(seed), 4'hf);
        end
        for (int i = 0; i < palSize; i++) begin
            readCheck(addrBits'(palBase + 4 * i));
        end
        reportTest("register readback", axiErr == mark);

        mark = axiErr;
        configWrite(7'h10, 32'hdead_beef, 4'hf);
        readCheck(7'h10);
        readCheck(7'h0c);
        reportTest("unmapped address", axiErr == mark);

        mark = axiErr;
        configWrite(regScroll, 32'h0023_0045, 4'hf);
        configWrite(regScroll, 32'h00ab_00cd, 4'b0001);
        readCheck(regScroll);
        configWrite(regScroll, 32'h0100_0000, 4'b1000);
        readCheck(regScroll);
        configWrite(addrBits'(palBase + 8), 32'h0000_0a5f, 4'b0010);
        readCheck(addrBits'(palBase + 8));
        reportTest("partial write strobe", axiErr == mark);

        // config lands in vertical blanking, before each checked frame
        waitVsRise();
        runPattern(patSolid, "pattern solid");
        runPattern(patChecker, "pattern checker");
        runPattern(patBars, "pattern bars");

        // palette rewrites spread over a few lines of the picture
        mark    = pixErr + axiErr;
        visMark = visChecks;
        wait (vdump == 9'd100);
        for (int i = 0; i < 6; i++) begin
            waitTicks(700);
            configWrite(addrBits'(palBase + 8 * i + 4), $random(seed), 4'hf);
        end
        waitVsRise();
        if (visChecks - visMark < visPixels - 200) begin
            $display("live palette: far fewer pixels were checked than one frame holds");
            pixErr++;
            errors++;
        end
        reportTest("live palette", pixErr + axiErr == mark);

        if (hsMeas == 0 || vsMeas == 0 || vsLenMeas == 0 || hbMeas == 0 || vbMeas == 0) begin
            $display("raster timing: a sync or blank edge never appeared");
            rasterErr++;
            errors++;
        end
        reportTest("raster timing", rasterErr == 0);
        reportTest("blanking", blankErr == 0 && blankChecks > 0);

        $display("tests passed %0d, tests failed %0d, check errors %0d",
                 passTests, failTests, errors);
        if (errors == 0 && failTests == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
